// File: include/rsc_dec_defines.svh
// rsc decoder widths, table size and half-iteration gap
`ifndef RSC_DEC_DEFINES_SVH
`define RSC_DEC_DEFINES_SVH

// data widths
`define RSC_LLR_W   5   // systematic llr
`define RSC_EXT_W   6   // extrinsic, saturates to -32..31
`define RSC_ADDR_W  8   // duo-bit address, also sizes the extrinsic store
`define RSC_DTAG_W  2   // duo-bit tag
`define RSC_TAG_W   1   // block tag

// number of ptype entries in the permutation table
`define RSC_NPTYPE  4

// idle cycles between half-iterations
// must cover the addr -> data -> write-back latency
`define RSC_GAP     3

`endif

// File: hdl/rsc_dec_pkg.sv
// rsc decoder package: shared data types and control FSM states
`default_nettype none

`include "rsc_dec_defines.svh"

package rsc_dec_pkg;

  //------------------------------------------------
  // data types
  //------------------------------------------------

  typedef logic signed [`RSC_LLR_W-1:0] bit_llr_t;  // soft input, one bit of a pair
  typedef logic signed [`RSC_EXT_W-1:0] extr_t;     // extrinsic, one bit of a pair

  typedef logic [`RSC_ADDR_W-1:0] addr_t;  // duo-bit address
  typedef logic [`RSC_DTAG_W-1:0] dtag_t;  // per-pair tag from input buffer

  // index into the permutation table
  typedef logic [$clog2(`RSC_NPTYPE)-1:0] ptype_t;

  //------------------------------------------------
  // control FSM
  //------------------------------------------------

  typedef enum logic [1:0] {
    IDLE,  // wait for full input and empty output buffer
    RUN,   // issuing pair addresses
    GAP,   // drain write-back, rewind address gens
    DONE   // wait for last write-back
  } ctrl_state_t;

endpackage

`default_nettype wire

// File: hdl/rsc_dec_ptable.sv
// rsc permutation table: block size N, P0 and per-phase offsets for each ptype
`timescale 1ns/100ps
`default_nettype none

`include "rsc_dec_defines.svh"

module rsc_dec_ptable (
  input  logic                iclk,
  input  logic                rst,
  input  rsc_dec_pkg::ptype_t ptype,
  output rsc_dec_pkg::addr_t  n,
  output rsc_dec_pkg::addr_t  p0,
  output rsc_dec_pkg::addr_t  p [4]  // phase offsets, already mod N
);

  import rsc_dec_pkg::*;

  addr_t row [5];  // N, P0, P1, P2, P3

  // N/2 + pp, folded back into 0..N-1
  function automatic addr_t half_off(addr_t nn, addr_t pp);
    logic [`RSC_ADDR_W:0] s;
    s = {1'b0, nn >> 1} + {1'b0, pp};
    if (s >= {1'b0, nn}) begin
      s = s - {1'b0, nn};
    end
    return s[`RSC_ADDR_W-1:0];
  endfunction

  always_comb begin
    case (ptype)
      2'd0:    row = '{48, 11, 24, 0, 24};
      2'd1:    row = '{64, 7, 34, 32, 2};
      2'd2:    row = '{212, 13, 106, 108, 2};
      default: row = '{220, 23, 112, 4, 116};
    endcase
  end

  always_ff @(posedge iclk) begin
    if (rst) begin
      n  <= '0;
      p0 <= '0;
      p  <= '{default: '0};
    end else begin
      n    <= row[0];
      p0   <= row[1];
      p[0] <= '0;                    // phase 0 adds nothing
      p[1] <= half_off(row[0], row[2]);
      p[2] <= row[3];
      p[3] <= half_off(row[0], row[4]);
    end
  end

endmodule

`default_nettype wire

// File: hdl/rsc_dec_ctrl.sv
// rsc decoder control: block start, half-iteration schedule and data-valid timing
`timescale 1ns/100ps
`default_nettype none

`include "rsc_dec_defines.svh"

module rsc_dec_ctrl (
  input  logic               iclk,
  input  logic               rst,
  input  logic               buf_full,    // input buffer holds a block
  input  logic               obuf_empty,  // output buffer can take a block
  input  rsc_dec_pkg::addr_t n,
  input  logic [3:0]         niter,
  output logic               rempty,
  output logic               wfull,
  output logic               addr_clear,
  output logic               addr_enable,
  output logic               addr_pmode,
  output logic               dec_val,
  output logic               dec_first,
  output logic               dec_last
);

  import rsc_dec_pkg::*;

  localparam int GAP_W = $clog2(`RSC_GAP + 1);

  ctrl_state_t      state;
  addr_t            cnt;       // pair step inside a half-iteration
  addr_t            half_m1;   // N/2 - 1
  logic [4:0]       hcnt;      // half-iteration number
  logic [4:0]       hlast;     // index of final half-iteration
  logic [GAP_W-1:0] gcnt;
  logic             pair_end;
  logic             half_end;
  logic [1:0]       val_sr;
  logic [1:0]       first_sr;
  logic [1:0]       last_sr;
  logic [3:0]       eop_sr;    // last pair of the block, t+1 .. t+4

  assign half_m1  = (n >> 1) - 1'b1;
  assign pair_end = (cnt == half_m1);
  assign half_end = (hcnt == hlast);

  //------------------------------------------------
  // FSM
  //------------------------------------------------

  always_ff @(posedge iclk) begin
    if (rst) begin
      state <= IDLE;
      cnt   <= '0;
      hcnt  <= '0;
      hlast <= '0;
      gcnt  <= '0;
    end else begin
      case (state)
        IDLE: if (buf_full & obuf_empty) begin
          state <= GAP;  // first gap lets the table settle
          gcnt  <= '0;
          hcnt  <= '0;
          hlast <= (niter == '0) ? 5'd1 : {niter, 1'b0} - 5'd1;  // 2*niter halves
        end
        GAP: begin
          gcnt <= gcnt + 1'b1;
          if (gcnt == GAP_W'(`RSC_GAP - 1)) begin
            state <= RUN;
            cnt   <= '0;
          end
        end
        RUN: begin
          cnt <= cnt + 1'b1;
          if (pair_end) begin
            if (half_end) begin
              state <= DONE;
            end else begin
              state <= GAP;
              gcnt  <= '0;
              hcnt  <= hcnt + 1'b1;
            end
          end
        end
        DONE: if (wfull) state <= IDLE;  // last write-back seen
        default: state <= IDLE;
      endcase
    end
  end

  assign addr_enable = (state == RUN);
  assign addr_clear  = (state == GAP);  // rewind both sweeps
  assign addr_pmode  = hcnt[0];         // odd halves use interleaved order

  //------------------------------------------------
  // align flags with buffer and extrinsic read data
  //------------------------------------------------

  always_ff @(posedge iclk) begin
    if (rst) begin
      val_sr   <= '0;
      first_sr <= '0;
      last_sr  <= '0;
      eop_sr   <= '0;
    end else begin
      val_sr   <= {val_sr[0], addr_enable};
      first_sr <= {first_sr[0], addr_enable & (hcnt == '0)};
      last_sr  <= {last_sr[0], addr_enable & half_end};
      eop_sr   <= {eop_sr[2:0], addr_enable & pair_end & half_end};
    end
  end

  assign dec_val   = val_sr[1];
  assign dec_first = first_sr[1];
  assign dec_last  = last_sr[1];
  assign rempty    = eop_sr[0];  // input buffer no longer needed
  assign wfull     = eop_sr[3];  // one cycle after final write

endmodule

`default_nettype wire

// File: hdl/rsc_dec_addr_gen.sv
// rsc address generator: natural or dvb-rcs permuted duo-bit sweep
`timescale 1ns/100ps
`default_nettype none

`include "rsc_dec_defines.svh"

module rsc_dec_addr_gen #(
  parameter bit B_NF = 1'b0  // 0 sweeps j up from 0, 1 sweeps j down from N-1
) (
  input  logic               iclk,
  input  logic               rst,
  input  logic               clear,
  input  logic               enable,
  input  logic               pmode,
  input  rsc_dec_pkg::addr_t n,
  input  rsc_dec_pkg::addr_t p0,
  input  rsc_dec_pkg::addr_t p [4],
  output rsc_dec_pkg::addr_t saddr
);

  import rsc_dec_pkg::*;

  localparam int SW = `RSC_ADDR_W + 1;  // room for a sum below 2N

  addr_t         j;        // running pair step
  addr_t         pj;       // P0*j mod N
  addr_t         j_init;
  addr_t         pj_init;
  addr_t         pj_next;
  addr_t         paddr;    // permuted address of step j
  logic [SW-1:0] pstep;
  logic [SW-1:0] psum;

  always_comb begin
    // sweep start point
    if (B_NF) begin
      j_init  = n - 1'b1;
      pj_init = (p0 == '0) ? '0 : n - p0;  // P0*(N-1) mod N
    end else begin
      j_init  = '0;
      pj_init = '0;
    end

    // P0*j kept mod N by add or subtract, no multiplier
    pstep = {1'b0, pj} + {1'b0, p0};
    if (B_NF) begin
      pj_next = (pj >= p0) ? pj - p0 : pj + n - p0;
    end else begin
      pj_next = (pstep >= {1'b0, n}) ? pj + p0 - n : pj + p0;
    end

    // P0*j + Pj + 1, one fold is enough
    psum  = {1'b0, pj} + {1'b0, p[j[1:0]]} + 1'b1;
    paddr = (psum >= {1'b0, n}) ? psum[`RSC_ADDR_W-1:0] - n : psum[`RSC_ADDR_W-1:0];
  end

  always_ff @(posedge iclk) begin
    if (rst) begin
      j     <= '0;
      pj    <= '0;
      saddr <= '0;
    end else if (clear) begin
      j  <= j_init;
      pj <= pj_init;
    end else if (enable) begin
      saddr <= pmode ? paddr : j;
      j     <= B_NF ? j - 1'b1 : j + 1'b1;
      pj    <= pj_next;
    end
  end

endmodule

`default_nettype wire

// File: hdl/rsc_dec_extr_ram.sv
// rsc extrinsic store: two write ports, two registered read ports, one pair per word
`timescale 1ns/100ps
`default_nettype none

`include "rsc_dec_defines.svh"

module rsc_dec_extr_ram (
  input  logic                iclk,
  input  logic                write,
  input  rsc_dec_pkg::addr_t  waddr0,
  input  rsc_dec_pkg::addr_t  waddr1,
  input  rsc_dec_pkg::addr_t  raddr0,
  input  rsc_dec_pkg::addr_t  raddr1,
  input  rsc_dec_pkg::extr_t  wdata0 [2],
  input  rsc_dec_pkg::extr_t  wdata1 [2],
  output rsc_dec_pkg::extr_t  rdata0 [2],
  output rsc_dec_pkg::extr_t  rdata1 [2]
);

  import rsc_dec_pkg::*;

  localparam int DEPTH = 2 ** `RSC_ADDR_W;
  localparam int WW    = 2 * `RSC_EXT_W;  // both bits of a pair

  logic [WW-1:0] mem [DEPTH];
  logic [WW-1:0] rword0;
  logic [WW-1:0] rword1;

  // forward and backward lanes never hit the same address in one half
  always_ff @(posedge iclk) begin
    if (write) begin
      mem[waddr0] <= {wdata0[1], wdata0[0]};
      mem[waddr1] <= {wdata1[1], wdata1[0]};
    end
    rword0 <= mem[raddr0];
    rword1 <= mem[raddr1];
  end

  assign rdata0[0] = rword0[`RSC_EXT_W-1:0];
  assign rdata0[1] = rword0[WW-1:`RSC_EXT_W];
  assign rdata1[0] = rword1[`RSC_EXT_W-1:0];
  assign rdata1[1] = rword1[WW-1:`RSC_EXT_W];

endmodule

`default_nettype wire

// File: hdl/rsc_dec_llr_accum.sv
// rsc lane update: saturated extrinsic accumulate and hard duo-bit decision
`timescale 1ns/100ps
`default_nettype none

`include "rsc_dec_defines.svh"

module rsc_dec_llr_accum (
  input  logic                 iclk,
  input  logic                 rst,
  input  logic                 val,
  input  logic                 first,   // first half, stored extrinsic is stale
  input  logic                 last,    // final half, emit decisions
  input  rsc_dec_pkg::addr_t   addr,    // one cycle ahead of data
  input  rsc_dec_pkg::bit_llr_t sllr [2],
  input  rsc_dec_pkg::dtag_t   stag,
  input  rsc_dec_pkg::extr_t   extr [2],
  output logic                 wr,
  output logic                 dat_val,
  output rsc_dec_pkg::addr_t   waddr,
  output rsc_dec_pkg::extr_t   wextr [2],
  output logic [1:0]           dat,
  output rsc_dec_pkg::dtag_t   dtag
);

  import rsc_dec_pkg::*;

  localparam int SUM_W = `RSC_EXT_W + 1;
  localparam logic signed [SUM_W-1:0] EXT_MAX = SUM_W'((1 << (`RSC_EXT_W - 1)) - 1);
  localparam logic signed [SUM_W-1:0] EXT_MIN = SUM_W'(-EXT_MAX - 1);

  addr_t                   addr_q;
  logic signed [SUM_W-1:0] e_old [2];
  logic signed [SUM_W-1:0] sum [2];
  extr_t                   sat [2];

  always_comb begin
    for (int k = 0; k < 2; k++) begin
      e_old[k] = first ? '0 : SUM_W'(extr[k]);  // sign extended
      sum[k]   = SUM_W'(sllr[k]) + e_old[k];
      if (sum[k] > EXT_MAX) begin
        sat[k] = EXT_MAX[`RSC_EXT_W-1:0];
      end else if (sum[k] < EXT_MIN) begin
        sat[k] = EXT_MIN[`RSC_EXT_W-1:0];
      end else begin
        sat[k] = sum[k][`RSC_EXT_W-1:0];
      end
    end
  end

  // payload path
  always_ff @(posedge iclk) begin
    addr_q <= addr;
    waddr  <= addr_q;  // write back where it was read
    wextr  <= sat;
    dtag   <= stag;
    if (val & last) begin
      dat <= {sum[1][SUM_W-1], sum[0][SUM_W-1]};  // 1 when negative
    end
  end

  always_ff @(posedge iclk) begin
    if (rst) begin
      wr      <= 1'b0;
      dat_val <= 1'b0;
    end else begin
      wr      <= val;
      dat_val <= val & last;
    end
  end

endmodule

`default_nettype wire

// File: hdl/rsc_dec_engine.sv
// rsc decoder engine top: table, scheduler, address sweeps, extrinsic store and lanes
`timescale 1ns/100ps
`default_nettype none

`include "rsc_dec_defines.svh"

module rsc_dec_engine (
  input  logic                  iclk,
  input  logic                  rst,
  input  logic                  irbuf_full,
  input  logic                  iwbuf_empty,
  input  rsc_dec_pkg::ptype_t   icode_ctx_ptype,
  input  logic [3:0]            iNiter,
  input  logic [`RSC_TAG_W-1:0] irtag,
  input  rsc_dec_pkg::bit_llr_t irfsLLR [2],
  input  rsc_dec_pkg::bit_llr_t irbsLLR [2],
  input  rsc_dec_pkg::dtag_t    irfsLLRtag,
  input  rsc_dec_pkg::dtag_t    irbsLLRtag,
  output logic                  orempty,
  output logic                  owrite,
  output logic                  owfull,
  output rsc_dec_pkg::addr_t    ownum,
  output logic [`RSC_TAG_W-1:0] owtag,
  output rsc_dec_pkg::addr_t    ofsaddr,
  output rsc_dec_pkg::addr_t    obsaddr,
  output rsc_dec_pkg::addr_t    owfaddr,
  output rsc_dec_pkg::addr_t    owbaddr,
  output logic [1:0]            owfdat,
  output logic [1:0]            owbdat,
  output rsc_dec_pkg::dtag_t    owfdtag,
  output rsc_dec_pkg::dtag_t    owbdtag
);

  import rsc_dec_pkg::*;

  ptype_t ptype_q;      // block ptype, held for the whole block
  logic   blk_act;      // mirrors ctrl leaving IDLE
  logic   blk_start;
  addr_t  n;
  addr_t  p0;
  addr_t  p [4];
  logic   addr_clear;
  logic   addr_enable;
  logic   addr_pmode;
  logic   dec_val;
  logic   dec_first;
  logic   dec_last;
  logic   f_wr;
  extr_t  f_extr [2];
  extr_t  b_extr [2];
  extr_t  f_wextr [2];
  extr_t  b_wextr [2];

  //------------------------------------------------
  // block context
  //------------------------------------------------

  assign blk_start = irbuf_full & iwbuf_empty & ~blk_act;  // same test as ctrl IDLE

  always_ff @(posedge iclk) begin
    if (rst) begin
      blk_act <= 1'b0;
      ptype_q <= '0;
      owtag   <= '0;
    end else if (blk_start) begin
      blk_act <= 1'b1;
      ptype_q <= icode_ctx_ptype;
      owtag   <= irtag;
    end else if (owfull) begin
      blk_act <= 1'b0;
    end
  end

  assign ownum = n;

  rsc_dec_ptable u_ptable (
    .iclk  (iclk),
    .rst   (rst),
    .ptype (ptype_q),
    .n     (n),
    .p0    (p0),
    .p     (p)
  );

  rsc_dec_ctrl u_ctrl (
    .iclk        (iclk),
    .rst         (rst),
    .buf_full    (irbuf_full),
    .obuf_empty  (iwbuf_empty),
    .n           (n),
    .niter       (iNiter),
    .rempty      (orempty),
    .wfull       (owfull),
    .addr_clear  (addr_clear),
    .addr_enable (addr_enable),
    .addr_pmode  (addr_pmode),
    .dec_val     (dec_val),
    .dec_first   (dec_first),
    .dec_last    (dec_last)
  );

  //------------------------------------------------
  // address sweeps, lower and upper half of j
  //------------------------------------------------

  rsc_dec_addr_gen #(.B_NF(1'b0)) u_faddr_gen (
    .iclk   (iclk),
    .rst    (rst),
    .clear  (addr_clear),
    .enable (addr_enable),
    .pmode  (addr_pmode),
    .n      (n),
    .p0     (p0),
    .p      (p),
    .saddr  (ofsaddr)
  );

  rsc_dec_addr_gen #(.B_NF(1'b1)) u_baddr_gen (
    .iclk   (iclk),
    .rst    (rst),
    .clear  (addr_clear),
    .enable (addr_enable),
    .pmode  (addr_pmode),
    .n      (n),
    .p0     (p0),
    .p      (p),
    .saddr  (obsaddr)
  );

  rsc_dec_extr_ram u_extr_ram (
    .iclk   (iclk),
    .write  (f_wr),      // both lanes write in lockstep
    .waddr0 (owfaddr),
    .waddr1 (owbaddr),
    .raddr0 (ofsaddr),
    .raddr1 (obsaddr),
    .wdata0 (f_wextr),
    .wdata1 (b_wextr),
    .rdata0 (f_extr),
    .rdata1 (b_extr)
  );

  //------------------------------------------------
  // forward and backward lanes
  //------------------------------------------------

  rsc_dec_llr_accum u_faccum (
    .iclk    (iclk),
    .rst     (rst),
    .val     (dec_val),
    .first   (dec_first),
    .last    (dec_last),
    .addr    (ofsaddr),
    .sllr    (irfsLLR),
    .stag    (irfsLLRtag),
    .extr    (f_extr),
    .wr      (f_wr),
    .dat_val (owrite),
    .waddr   (owfaddr),
    .wextr   (f_wextr),
    .dat     (owfdat),
    .dtag    (owfdtag)
  );

  // strobes match the forward lane cycle for cycle
  rsc_dec_llr_accum u_baccum (
    .iclk    (iclk),
    .rst     (rst),
    .val     (dec_val),
    .first   (dec_first),
    .last    (dec_last),
    .addr    (obsaddr),
    .sllr    (irbsLLR),
    .stag    (irbsLLRtag),
    .extr    (b_extr),
    .wr      (),
    .dat_val (),
    .waddr   (owbaddr),
    .wextr   (b_wextr),
    .dat     (owbdat),
    .dtag    (owbdtag)
  );

endmodule

`default_nettype wire

// File: verif/rsc_dec_engine_tb.sv
// rsc decoder engine testbench: input buffer model, per-bit reference and directed tests
`timescale 1ns/100ps
`default_nettype none

`include "rsc_dec_defines.svh"

module rsc_dec_engine_tb;

  import rsc_dec_pkg::*;

  localparam int BLK_TIMEOUT = 20000;  // cycles, longest block is ~3.5k

  logic                  iclk;
  logic                  rst;
  logic                  irbuf_full;
  logic                  iwbuf_empty;
  ptype_t                icode_ctx_ptype;
  logic [3:0]            iNiter;
  logic [`RSC_TAG_W-1:0] irtag;
  bit_llr_t              irfs_llr [2];
  bit_llr_t              irbs_llr [2];
  dtag_t                 irfs_tag;
  dtag_t                 irbs_tag;
  logic                  orempty;
  logic                  owrite;
  logic                  owfull;
  addr_t                 ownum;
  logic [`RSC_TAG_W-1:0] owtag;
  addr_t                 ofsaddr;
  addr_t                 obsaddr;
  addr_t                 owfaddr;
  addr_t                 owbaddr;
  logic [1:0]            owfdat;
  logic [1:0]            owbdat;
  dtag_t                 owfdtag;
  dtag_t                 owbdtag;

  // input buffer contents, one pair per address
  bit_llr_t llr0 [256];
  bit_llr_t llr1 [256];
  dtag_t    tags [256];
  addr_t    f_pend;  // address seen last cycle
  addr_t    b_pend;

  // one entry per owrite of the last block
  logic [31:0] q_faddr [$];
  logic [31:0] q_baddr [$];
  logic [31:0] q_fdat [$];
  logic [31:0] q_bdat [$];
  logic [31:0] q_ftag [$];
  logic [31:0] q_btag [$];

  rsc_dec_engine DUT (
    .iclk            (iclk),
    .rst             (rst),
    .irbuf_full      (irbuf_full),
    .iwbuf_empty     (iwbuf_empty),
    .icode_ctx_ptype (icode_ctx_ptype),
    .iNiter          (iNiter),
    .irtag           (irtag),
    .irfsLLR         (irfs_llr),
    .irbsLLR         (irbs_llr),
    .irfsLLRtag      (irfs_tag),
    .irbsLLRtag      (irbs_tag),
    .orempty         (orempty),
    .owrite          (owrite),
    .owfull          (owfull),
    .ownum           (ownum),
    .owtag           (owtag),
    .ofsaddr         (ofsaddr),
    .obsaddr         (obsaddr),
    .owfaddr         (owfaddr),
    .owbaddr         (owbaddr),
    .owfdat          (owfdat),
    .owbdat          (owbdat),
    .owfdtag         (owfdtag),
    .owbdtag         (owbdtag)
  );

  always #10 iclk = ~iclk;  // 20 ns period

  // input buffer: data for an address comes back one cycle later
  always @(posedge iclk) begin
    #1;
    irfs_llr[0] = llr0[f_pend];
    irfs_llr[1] = llr1[f_pend];
    irfs_tag    = tags[f_pend];
    irbs_llr[0] = llr0[b_pend];
    irbs_llr[1] = llr1[b_pend];
    irbs_tag    = tags[b_pend];
    f_pend      = ofsaddr;
    b_pend      = obsaddr;
  end

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------

  // N, P0, P1, P2, P3 per ptype
  function automatic int ptab(input int pt, input int col);
    int row [5];
    case (pt)
      0:       row = '{48, 11, 24, 0, 24};
      1:       row = '{64, 7, 34, 32, 2};
      2:       row = '{212, 13, 106, 108, 2};
      default: row = '{220, 23, 112, 4, 116};
    endcase
    return row[col];
  endfunction

  // dvb-rcs interleaved address of pair step j
  function automatic int perm_addr(input int pt, input int j);
    int nn;
    int pj;
    nn = ptab(pt, 0);
    case (j % 4)
      0:       pj = 0;
      1:       pj = nn / 2 + ptab(pt, 2);
      2:       pj = ptab(pt, 3);
      default: pj = nn / 2 + ptab(pt, 4);
    endcase
    return (ptab(pt, 1) * j + pj + 1) % nn;
  endfunction

  function automatic int num_halves(input int niter);
    return (niter == 0) ? 2 : 2 * niter;
  endfunction

  // extrinsic updated h-1 times, decision on the last half
  function automatic int hard_bit(input int s, input int h);
    int e;
    int k;
    e = 0;
    for (k = 0; k < h - 1; k++) begin
      e = s + e;
      if (e > 31) e = 31;
      else if (e < -32) e = -32;  // 6-bit saturation
    end
    return (s + e < 0) ? 1 : 0;
  endfunction

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      report_error($sformatf("MISMATCH %s: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  task automatic fill_buffer();
    int a;
    for (a = 0; a < 256; a++) begin
      llr0[a] = bit_llr_t'($urandom % 32);  // -16..15
      llr1[a] = bit_llr_t'($urandom % 32);
      tags[a] = dtag_t'($urandom % 4);
    end
  endtask

  // start one block, collect owrite data until owfull
  task automatic run_block(input string name, input int pt, input int niter, input int tag);
    int cyc;
    int n_rempty;
    bit done;
    q_faddr.delete();
    q_baddr.delete();
    q_fdat.delete();
    q_bdat.delete();
    q_ftag.delete();
    q_btag.delete();
    @(posedge iclk);
    #1;
    icode_ctx_ptype = ptype_t'(pt);
    iNiter          = niter[3:0];
    irtag           = tag[`RSC_TAG_W-1:0];
    irbuf_full      = 1'b1;
    iwbuf_empty     = 1'b1;
    @(posedge iclk);
    #1;
    irbuf_full  = 1'b0;  // block taken, drop both levels
    iwbuf_empty = 1'b0;
    n_rempty    = 0;
    done        = 1'b0;
    cyc         = 0;
    while (!done) begin
      @(posedge iclk);
      #1;
      cyc++;
      if (orempty) n_rempty++;
      if (owrite) begin
        q_faddr.push_back(owfaddr);
        q_baddr.push_back(owbaddr);
        q_fdat.push_back(owfdat);
        q_bdat.push_back(owbdat);
        q_ftag.push_back(owfdtag);
        q_btag.push_back(owbdtag);
      end
      if (owfull) done = 1'b1;
      else if (cyc > BLK_TIMEOUT) report_error({name, ": owfull never came"});
    end
    check_val({name, " orempty before owfull"}, 1, n_rempty);
    check_val({name, " owtag"}, tag, owtag);
    check_val({name, " ownum"}, ptab(pt, 0), ownum);
    check_val({name, " owrite count"}, ptab(pt, 0) / 2, q_faddr.size());
    @(posedge iclk);
    #1;
    check_val({name, " owfull width"}, 0, owfull);  // one cycle pulse
    check_val({name, " late orempty"}, 0, orempty);
  endtask

  // addresses, tags and decisions of the last run against the model
  task automatic check_outputs(input string name, input int pt, input int niter);
    int k;
    int nn;
    int fa;
    int ba;
    int h;
    nn = ptab(pt, 0);
    h  = num_halves(niter);
    for (k = 0; k < nn / 2; k++) begin
      fa = perm_addr(pt, k);           // last half is always odd
      ba = perm_addr(pt, nn - 1 - k);  // backward sweep from the top
      check_val($sformatf("%s faddr[%0d]", name, k), fa, q_faddr[k]);
      check_val($sformatf("%s baddr[%0d]", name, k), ba, q_baddr[k]);
      check_val($sformatf("%s fdtag[%0d]", name, k), tags[fa], q_ftag[k]);
      check_val($sformatf("%s bdtag[%0d]", name, k), tags[ba], q_btag[k]);
      check_val($sformatf("%s fdat[%0d]", name, k),
                2 * hard_bit(llr1[fa], h) + hard_bit(llr0[fa], h), q_fdat[k]);
      check_val($sformatf("%s bdat[%0d]", name, k),
                2 * hard_bit(llr1[ba], h) + hard_bit(llr0[ba], h), q_bdat[k]);
    end
  endtask

  // --------------------------------------------------
  // directed tests
  // --------------------------------------------------

  task automatic idle_after_reset();
    int k;
    irbuf_full = 1'b0;
    for (k = 0; k < 20; k++) begin
      @(posedge iclk);
      #1;
      check_val("idle_after_reset orempty", 0, orempty);
      check_val("idle_after_reset owrite", 0, owrite);
      check_val("idle_after_reset owfull", 0, owfull);
    end
  endtask

  task automatic start_gating();
    int k;
    addr_t fa0;
    addr_t ba0;
    irbuf_full  = 1'b1;
    iwbuf_empty = 1'b0;  // output buffer busy
    fa0         = ofsaddr;
    ba0         = obsaddr;
    for (k = 0; k < 30; k++) begin
      @(posedge iclk);
      #1;
      check_val("start_gating orempty", 0, orempty);
      check_val("start_gating owrite", 0, owrite);
      check_val("start_gating owfull", 0, owfull);
      check_val("start_gating ofsaddr", fa0, ofsaddr);  // no sweep without a start
      check_val("start_gating obsaddr", ba0, obsaddr);
    end
    run_block("start_gating", 1, 1, 1);
  endtask

  task automatic permuted_order();
    fill_buffer();
    run_block("permuted_order", 0, 1, 0);
    check_val("permuted_order ownum", 48, ownum);
    check_outputs("permuted_order", 0, 1);
  endtask

  task automatic multi_iter_decisions();
    fill_buffer();
    // corner values at a few addresses
    llr0[0]  = -5'sd16;
    llr1[0]  = 5'sd15;
    llr0[5]  = 5'sd0;
    llr1[33] = 5'sd0;
    llr0[63] = 5'sd15;
    llr1[40] = -5'sd16;
    run_block("multi_iter_decisions", 1, 3, 1);
    check_outputs("multi_iter_decisions", 1, 3);
  endtask

  task automatic back_to_back_blocks();
    fill_buffer();
    run_block("back_to_back_blocks first", 2, 1, 0);
    check_outputs("back_to_back_blocks first", 2, 1);
    run_block("back_to_back_blocks second", 3, 2, 1);
    check_outputs("back_to_back_blocks second", 3, 2);
  endtask

  initial begin : main
    int seed_ret;
    iclk            = 1'b0;
    rst             = 1'b1;
    irbuf_full      = 1'b0;
    iwbuf_empty     = 1'b0;
    icode_ctx_ptype = '0;
    iNiter          = '0;
    irtag           = '0;
    irfs_llr[0]     = '0;
    irfs_llr[1]     = '0;
    irbs_llr[0]     = '0;
    irbs_llr[1]     = '0;
    irfs_tag        = '0;
    irbs_tag        = '0;
    f_pend          = '0;
    b_pend          = '0;
    seed_ret        = $urandom(90577);
    fill_buffer();
    repeat (8) @(posedge iclk);
    #1;
    rst = 1'b0;
    idle_after_reset();
    start_gating();
    permuted_order();
    multi_iter_decisions();
    back_to_back_blocks();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
hdl/rsc_dec_pkg.sv
hdl/rsc_dec_ptable.sv
hdl/rsc_dec_ctrl.sv
hdl/rsc_dec_addr_gen.sv
hdl/rsc_dec_extr_ram.sv
hdl/rsc_dec_llr_accum.sv
hdl/rsc_dec_engine.sv
verif/rsc_dec_engine_tb.sv
